/* fetchPcGen.sv */
module fetchPcGen (
    input  logic              Clock,
    input  logic              reset,
    input  logic              redirect,     // One-cycle pulse that starts or moves fetching
    input  ifuPkg::fetchAddrT redirectPc,
    input  logic              fetchAccept,  // Cache took the current address
    output logic              fetchValid,
    output ifuPkg::fetchAddrT fetchPc
);
    import ifuPkg::*;

    // The started flag stays high once the first redirect has been seen
    // A redirect wins over an accept in the same cycle, so an address that
    // was just accepted is dropped in favour of the new target
    always_ff @(posedge Clock) begin
        if (reset) begin
            fetchValid <= 1'b0;
            fetchPc    <= '0;
        end else begin
            if (redirect) begin
                fetchValid <= 1'b1;
                fetchPc    <= redirectPc;
            end else if (fetchAccept) begin
                fetchPc <= fetchPc + fetchAddrT'(4);  // Next sequential word
            end
        end
    end

endmodule

/* files.f */
ifuPkg.sv
fetchPcGen.sv
insCache.sv
insAligner.sv
ifuTop.sv
ifuTb.sv

/* ifuPkg.sv */
package ifuPkg;

    // Cache geometry
    localparam int NumLines     = 8;                        // Fully associative with a single set
    localparam int LineBytes    = 16;                       // Four instruction words per line
    localparam int OffsetWidth  = $clog2(LineBytes);        // Byte offset within a line
    localparam int AddrWidth    = 32;
    localparam int TagWidth     = AddrWidth - OffsetWidth;  // Line address without the offset
    localparam int WordSelWidth = 2;                        // Address bits 3:2 pick the word

    // Byte address of an instruction
    typedef logic [AddrWidth-1:0] fetchAddrT;

    // Line tag that doubles as the line address sent to memory
    typedef logic [TagWidth-1:0] lineTagT;

    // One cache line with word 0 in the low bits
    typedef logic [LineBytes*8-1:0] cacheLineT;

    // A single instruction word
    typedef logic [31:0] insWordT;

    // Line number inside the cache
    typedef logic [$clog2(NumLines)-1:0] lineIndexT;

    // One bit per inner node of the replacement tree with the root at bit 0
    typedef logic [NumLines-2:0] plruTreeT;

    // Miss machine of the cache
    typedef enum logic {
        Lookup,
        MissWait
    } cacheStateT;

endpackage

/* ifuStimulus.txt */
# Columns: name, start byte address (hex), instruction count, fill delay in cycles
# A fill delay of 0 picks a random delay of 1 to 4 cycles for each miss
warmFill     00001000  32  2
revisitLow   00001010   8  1
hitRun       00001020   8  2
midLine      00001044  10  0
walkNine     00002000  36  3
revisitOld   00002010  12  1
lowAgain     00001000  16  0
crossLine    00003ffc   5  4
shortHop     00001008   3  0
walkBack     00002080  20  2
tailHits     00002084   6  1

/* ifuTb.sv */
module ifuTb;
    timeunit 1ns;
    timeprecision 1ps;
    import ifuPkg::*;

    localparam logic [31:0] DataKey = 32'hA5A5_0000;  // Memory word is its byte address XOR this

    logic      Clock;
    logic      reset      = 1'b1;
    logic      redirect   = 1'b0;
    fetchAddrT redirectPc = '0;
    logic      fillValid  = 1'b0;
    cacheLineT fillLine   = '0;
    logic      memReq;
    lineTagT   memLineAddr;
    logic      insValid;
    insWordT   insWord;
    fetchAddrT insPc;

    string     stepName [$];
    fetchAddrT stepStart [$];
    int        stepCount [$];
    int        stepDelay [$];

    // Reference copy of the cache contents and replacement tree
    lineTagT             modelTag [NumLines];
    logic [NumLines-1:0] modelValid = '0;
    plruTreeT            modelTree  = '0;

    int        errorCount = 0;
    int        checkCount = 0;
    int        cycleCount = 0;
    int        limitCycles = 0;
    int        received = 0;
    int        stepTarget = 0;
    int        curDelay = 1;
    int        skipSamples = 0;   // Samples after a redirect that still carry the old stream
    int        lastInsCycle = -1;
    string     curName = "idle";
    fetchAddrT nextPc = '0;
    logic      started = 1'b0;
    logic      stallSeen = 1'b0;
    logic      allHit = 1'b0;
    logic      prevMemReq = 1'b0;

    ifuTop dut (
        .Clock       (Clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .fillValid   (fillValid),
        .fillLine    (fillLine),
        .memReq      (memReq),
        .memLineAddr (memLineAddr),
        .insValid    (insValid),
        .insWord     (insWord),
        .insPc       (insPc)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    function automatic insWordT wordAt(fetchAddrT addr);
        return addr ^ DataKey;
    endfunction

    function automatic cacheLineT memoryLine(lineTagT tag);
        cacheLineT line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = wordAt({tag, 4'h0} + fetchAddrT'(4 * w));
        end
        return line;
    endfunction

    function automatic int modelSlot(lineTagT tag);
        for (int i = 0; i < NumLines; i++) begin
            if (modelValid[i] && modelTag[i] == tag) return i;
        end
        return -1;
    endfunction

    // Set each node on the path so it points at the half holding the slot
    task automatic treeTouch(int slot);
        int node;
        int lo;
        int span;
        node = 0;
        lo   = 0;
        span = NumLines;
        while (span > 1) begin
            span = span / 2;
            modelTree[node] = (slot >= lo + span);  // 1 means the upper half was used
            if (slot >= lo + span) lo = lo + span;
            node = 2 * node + (modelTree[node] ? 2 : 1);
        end
    endtask

    function automatic int treeVictim();
        int node;
        int lo;
        int span;
        node = 0;
        lo   = 0;
        span = NumLines;
        while (span > 1) begin
            span = span / 2;
            if (modelTree[node] == 1'b0) begin
                lo   = lo + span;
                node = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        return lo;
    endfunction

    task automatic modelFill(lineTagT tag);
        int slot;
        slot = treeVictim();
        for (int i = NumLines - 1; i >= 0; i--) begin
            if (!modelValid[i]) slot = i;  // Lowest invalid slot beats the tree
        end
        modelTag[slot]   = tag;
        modelValid[slot] = 1'b1;
        treeTouch(slot);
    endtask

    function automatic logic stepResident(fetchAddrT start, int count);
        fetchAddrT pc;
        for (int k = 0; k < count; k++) begin
            pc = start + fetchAddrT'(4 * k);
            if (modelSlot(pc[AddrWidth-1:OffsetWidth]) < 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        assert (expected === actual) else begin
            errorCount++;
            $display("error %s %s: expected %h actual %h", curName, what, expected, actual);
        end
    endtask

    task automatic takeInstruction();
        fetchAddrT expectPc;
        int        slot;
        expectPc = (skipSamples == 0) ? nextPc : insPc;
        slot = modelSlot(insPc[AddrWidth-1:OffsetWidth]);
        checkCount++;
        assert (slot >= 0) else begin
            errorCount++;
            $display("Step %s returned %h from a line the model does not hold", curName, insPc);
        end
        if (slot >= 0) treeTouch(slot);
        checkValue("word", wordAt(expectPc), insWord);
        if (skipSamples == 0) begin
            checkValue("pc", expectPc, insPc);
            if (allHit && !stallSeen && lastInsCycle >= 0) begin
                checkValue("gap", 32'd1, 32'(cycleCount - lastInsCycle));
            end
            lastInsCycle = cycleCount;
            nextPc = expectPc + 32'd4;  // Next address in program order
            received++;
        end
    endtask

    task automatic takeRequest();
        checkCount++;
        assert (modelSlot(memLineAddr) < 0) else begin
            errorCount++;
            $display("Step %s requested line %h that the model holds", curName, memLineAddr);
        end
        if (skipSamples <= 1) begin
            checkValue("miss line", fetchAddrT'(nextPc[AddrWidth-1:OffsetWidth]),
                       fetchAddrT'(memLineAddr));
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge Clock) begin
        if (!reset) begin
            if (!started) begin
                checkCount++;
                assert (insValid === 1'b0 && memReq === 1'b0) else begin
                    errorCount++;
                    $display("Strobe active before the first redirect: insValid %b memReq %b",
                             insValid, memReq);
                end
            end else begin
                if (memReq === 1'b1) stallSeen = 1'b1;
                if (skipSamples == 3) allHit = stepResident(nextPc, stepTarget);
                if (insValid === 1'b1) takeInstruction();
                if (memReq === 1'b1 && !prevMemReq) takeRequest();
                if (skipSamples > 0) skipSamples--;
            end
            prevMemReq = (memReq === 1'b1);
        end
    end

    // Memory answers each request after the step's delay
    initial begin : memoryModel
        lineTagT reqTag;
        int      waitCycles;
        forever begin
            @(negedge Clock);
            if (!reset && memReq === 1'b1) begin
                reqTag     = memLineAddr;
                waitCycles = (curDelay == 0) ? int'($urandom_range(4, 1)) : curDelay;
                repeat (waitCycles) @(posedge Clock);
                fillLine  <= memoryLine(reqTag);
                fillValid <= 1'b1;
                modelFill(reqTag);
                @(posedge Clock);
                fillValid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (limitCycles > 0);
        while (cycleCount < limitCycles) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout: step %s still running after %0d cycles", curName, cycleCount);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        $display("Checks failed");
        $finish;
    end

    task automatic loadStimulus(output logic ok);
        int        fd;
        string     text;
        string     name;
        fetchAddrT start;
        int        count;
        int        delay;
        ok = 1'b0;
        fd = $fopen("ifuStimulus.txt", "r");
        if (fd != 0) begin
            while ($fgets(text, fd) > 0) begin
                if (text.len() > 1 && text[0] != "#") begin
                    if ($sscanf(text, "%s %h %d %d", name, start, count, delay) == 4) begin
                        stepName.push_back(name);
                        stepStart.push_back(start);
                        stepCount.push_back(count);
                        stepDelay.push_back(delay);
                    end
                end
            end
            $fclose(fd);
            ok = (stepName.size() > 0);
        end
    endtask

    initial begin : mainSequence
        logic ok;
        int   budget;
        void'($urandom(12));
        loadStimulus(ok);
        budget = 200;
        foreach (stepCount[s]) begin
            budget += stepCount[s] * (((stepDelay[s] == 0) ? 4 : stepDelay[s]) + 4);
        end
        if (!ok) begin
            $display("Stimulus file ifuStimulus.txt is missing or holds no steps");
            $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
            $display("Checks failed");
            $finish;
        end else begin
            limitCycles = budget;
            repeat (5) @(posedge Clock);
            reset <= 1'b0;
            repeat (4) @(posedge Clock);  // Quiet window before any redirect
            for (int s = 0; s < stepName.size(); s++) begin
                @(posedge Clock);
                redirect     <= 1'b1;
                redirectPc   <= stepStart[s];
                curName      = stepName[s];
                curDelay     = stepDelay[s];
                stepTarget   = stepCount[s];
                received     = 0;
                nextPc       = stepStart[s];
                skipSamples  = 3;
                lastInsCycle = -1;
                stallSeen    = 1'b0;
                started      = 1'b1;
                @(posedge Clock);
                redirect <= 1'b0;
                wait (received >= stepTarget);
            end
            repeat (10) @(posedge Clock);
            $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

/* ifuTop.sv */
module ifuTop (
    input  logic              Clock,
    input  logic              reset,
    input  logic              redirect,
    input  ifuPkg::fetchAddrT redirectPc,
    input  logic              fillValid,
    input  ifuPkg::cacheLineT fillLine,
    output logic              memReq,
    output ifuPkg::lineTagT   memLineAddr,
    output logic              insValid,
    output ifuPkg::insWordT   insWord,
    output ifuPkg::fetchAddrT insPc
);
    import ifuPkg::*;

    logic      fetchValid;
    fetchAddrT fetchPc;
    logic      fetchAccept;   // Cache hit on the presented address
    logic      lineValid;
    cacheLineT hitLine;
    fetchAddrT hitPc;

    fetchPcGen pcGen (
        .Clock       (Clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .fetchAccept (fetchAccept),
        .fetchValid  (fetchValid),
        .fetchPc     (fetchPc)
    );

    insCache cache (
        .Clock       (Clock),
        .reset       (reset),
        .fetchValid  (fetchValid),
        .fetchPc     (fetchPc),
        .fillValid   (fillValid),
        .fillLine    (fillLine),
        .fetchAccept (fetchAccept),
        .memReq      (memReq),
        .memLineAddr (memLineAddr),
        .lineValid   (lineValid),
        .hitLine     (hitLine),
        .hitPc       (hitPc)
    );

    insAligner aligner (
        .Clock     (Clock),
        .reset     (reset),
        .lineValid (lineValid),
        .hitLine   (hitLine),
        .hitPc     (hitPc),
        .insValid  (insValid),
        .insWord   (insWord),
        .insPc     (insPc)
    );

endmodule

/* insAligner.sv */
module insAligner (
    input  logic              Clock,
    input  logic              reset,
    input  logic              lineValid,
    input  ifuPkg::cacheLineT hitLine,
    input  ifuPkg::fetchAddrT hitPc,
    output logic              insValid,
    output ifuPkg::insWordT   insWord,
    output ifuPkg::fetchAddrT insPc
);
    import ifuPkg::*;

    logic [WordSelWidth-1:0] wordSel;
    insWordT                 selWord;

    // Address bits just above the byte offset within a word
    assign wordSel = hitPc[OffsetWidth-1:OffsetWidth-WordSelWidth];

    assign selWord = hitLine[wordSel*$bits(insWordT) +: $bits(insWordT)];  // Word 0 is low

    always_ff @(posedge Clock) begin
        if (reset) begin
            insValid <= 1'b0;
        end else begin
            insValid <= lineValid;
        end
    end

    // Word and address of the instruction leaving the stage
    always_ff @(posedge Clock) begin
        if (lineValid) begin
            insWord <= selWord;
            insPc   <= hitPc;
        end
    end

endmodule

/* insCache.sv */
module insCache (
    input  logic              Clock,
    input  logic              reset,
    input  logic              fetchValid,
    input  ifuPkg::fetchAddrT fetchPc,
    input  logic              fillValid,    // One-cycle strobe from memory
    input  ifuPkg::cacheLineT fillLine,
    output logic              fetchAccept,
    output logic              memReq,       // Level that stays high while a miss is outstanding
    output ifuPkg::lineTagT   memLineAddr,
    output logic              lineValid,
    output ifuPkg::cacheLineT hitLine,
    output ifuPkg::fetchAddrT hitPc
);
    import ifuPkg::*;

    cacheStateT             state;
    lineTagT                tagArr [NumLines];
    cacheLineT              dataArr [NumLines];
    logic [NumLines-1:0]    validArr;
    plruTreeT               plruTree;
    lineTagT                missTag;       // Tag of the line being fetched from memory

    lineTagT                pcTag;
    logic                   hit;
    lineIndexT              hitIdx;
    logic                   anyFree;
    lineIndexT              freeIdx;
    lineIndexT              victimIdx;
    logic                   startMiss;
    logic                   fillDone;

    // Mark the path from the root to the touched line. Each node bit points
    // toward the most recently used half
    function automatic plruTreeT plruTouch(plruTreeT tree, lineIndexT line);
        plruTreeT next;
        int       node;
        next = tree;
        node = 0;
        for (int level = $bits(lineIndexT) - 1; level >= 0; level--) begin
            next[node] = line[level];
            node       = 2 * node + 1 + int'(line[level]);
        end
        return next;
    endfunction

    // Walk away from the recently used side at every node
    function automatic lineIndexT plruVictim(plruTreeT tree);
        lineIndexT victim;
        int        node;
        victim = '0;
        node   = 0;
        for (int level = $bits(lineIndexT) - 1; level >= 0; level--) begin
            victim[level] = ~tree[node];
            node          = 2 * node + 1 + int'(victim[level]);
        end
        return victim;
    endfunction

    assign pcTag = fetchPc[AddrWidth-1:OffsetWidth];

    // Parallel tag compare over all lines
    always_comb begin
        hit    = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < NumLines; i++) begin
            if (validArr[i] && tagArr[i] == pcTag && !hit) begin
                hit    = 1'b1;
                hitIdx = lineIndexT'(i);
            end
        end
    end

    // First invalid line in index order, otherwise the tree decides
    always_comb begin
        anyFree = 1'b0;
        freeIdx = '0;
        for (int i = 0; i < NumLines; i++) begin
            if (!validArr[i] && !anyFree) begin
                anyFree = 1'b1;
                freeIdx = lineIndexT'(i);
            end
        end
        victimIdx = anyFree ? freeIdx : plruVictim(plruTree);
    end

    assign fetchAccept = (state == Lookup) && fetchValid && hit;
    assign startMiss   = (state == Lookup) && fetchValid && !hit;
    assign fillDone    = (state == MissWait) && fillValid;

    assign memReq      = (state == MissWait);
    assign memLineAddr = missTag;

    // Control state
    always_ff @(posedge Clock) begin
        if (reset) begin
            state     <= Lookup;
            validArr  <= '0;
            plruTree  <= '0;
            lineValid <= 1'b0;
        end else begin
            lineValid <= fetchAccept;  // Line leaves one cycle after the accept
            case (state)
                Lookup: begin
                    if (fetchAccept) begin
                        plruTree <= plruTouch(plruTree, hitIdx);
                    end else if (startMiss) begin
                        state <= MissWait;
                    end
                end
                MissWait: begin
                    if (fillDone) begin
                        validArr[victimIdx] <= 1'b1;
                        plruTree            <= plruTouch(plruTree, victimIdx);
                        state               <= Lookup;  // Held address hits next cycle
                    end
                end
                default: state <= Lookup;
            endcase
        end
    end

    // Arrays and the registered line for the aligner
    always_ff @(posedge Clock) begin
        if (startMiss) begin
            missTag <= pcTag;
        end
        if (fillDone) begin
            tagArr[victimIdx]  <= missTag;
            dataArr[victimIdx] <= fillLine;
        end
        if (fetchAccept) begin
            hitLine <= dataArr[hitIdx];
            hitPc   <= fetchPc;
        end
    end

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module ifuTb -f files.f -o ifuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ifuSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
